// ==== hw/fix_defines.svh ====
/*
 * fix parser constants
 * delimiter characters and the lane none code
 * tag and value limits, pair queue depth
 */
`ifndef FIX_DEFINES_SVH
`define FIX_DEFINES_SVH

// field delimiter and tag/value separator
`define FIX_SOH_CHAR 8'h01
`define FIX_SEP_CHAR 8'h3D

// lane code for a delimiter absent from the word
`define FIX_POS_NONE 3'd7

// longest value in bytes, longest tag in digits
`define FIX_VALUE_BYTES 8
`define FIX_TAG_DIGITS 4

// entries of the pair queue
`define FIX_QUEUE_DEPTH 4

`endif

// ==== hw/fix_proto_pkg.sv ====
/*
 * protocol types of the fix parser
 * delimiter lane position and field parse state
 */
package fix_proto_pkg;

	// byte lanes per bus word, lane 3 holds the first byte
	localparam int LANES = 4;

	// lane 3..0 of a delimiter, or the none code
	typedef logic [2:0] lane_pos_t;

	// parse state carried from word to word
	// SKIP drops bytes after an error until the next SOH
	typedef enum logic [1:0] {
		IN_TAG   = 2'd0,
		IN_VALUE = 2'd1,
		SKIP     = 2'd2
	} field_state_e;

endpackage

// ==== hw/fix_bus_pkg.sv ====
/*
 * wishbone side of the fix parser
 * register word addresses and status field layout
 */
package fix_bus_pkg;

	// word addresses, VAL_LO read pops the queue
	typedef enum logic [2:0] {
		REG_DATA    = 3'd0,
		REG_STATUS  = 3'd1,
		REG_TAG     = 3'd2,
		REG_VAL_HI  = 3'd3,
		REG_VAL_LO  = 3'd4,
		REG_VAL_LEN = 3'd5
	} reg_addr_e;

	// status word: count in 2:0, errors in 6:4
	localparam int COUNT_BITS = 3;
	localparam int ERR_BITS = 3;
	localparam int ERR_LSB = 4;

	// sticky error flag positions
	localparam int ERR_BAD_WORD = 0;
	localparam int ERR_BAD_TAG = 1;
	localparam int ERR_LONG_VAL = 2;

endpackage

// ==== hw/fix_delim_finder.sv ====
/*
 * fix_delim_finder
 * lane of the SOH and of the '=' in one bus word,
 * with a flag for words holding either one twice
 */
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_delim_finder (
	input  logic [31:0]              word_i,
	output fix_proto_pkg::lane_pos_t soh_pos_o,
	output fix_proto_pkg::lane_pos_t sep_pos_o,
	output logic                     bad_word_o
);
	import fix_proto_pkg::*;

	logic [LANES-1:0] soh_hit;
	logic [LANES-1:0] sep_hit;

	// one compare per byte lane
	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			soh_hit[k] = (word_i[8*k +: 8] == `FIX_SOH_CHAR);
			sep_hit[k] = (word_i[8*k +: 8] == `FIX_SEP_CHAR);
		end
	end

	// encode the hit lane, none when absent
	always_comb begin
		soh_pos_o = `FIX_POS_NONE;
		sep_pos_o = `FIX_POS_NONE;
		for (int k = 0; k < LANES; k++) begin
			if (soh_hit[k])
				soh_pos_o = lane_pos_t'(k);
			if (sep_hit[k])
				sep_pos_o = lane_pos_t'(k);
		end
	end

	// a second copy of either delimiter is outside the splitter cases
	assign bad_word_o = ($countones(soh_hit) > 1) || ($countones(sep_hit) > 1);

endmodule

// ==== hw/fix_field_splitter.sv ====
/*
 * fix_field_splitter
 * splits one word into tag and value lanes around the delimiters
 * and reports which field the word leaves open
 */
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_field_splitter (
	input  logic [31:0]              data_i,
	input  fix_proto_pkg::lane_pos_t soh_i,
	input  fix_proto_pkg::lane_pos_t sep_i,
	input  logic                     tag_status_i,
	input  logic                     value_status_i,
	output logic [31:0]              out_o,
	output logic [3:0]               tag_valid_o,
	output logic [3:0]               value_valid_o,
	output logic                     tag_status_o,
	output logic                     value_status_o
);
	import fix_proto_pkg::*;

	logic soh_here;
	logic sep_here;
	// SOH sits in a later lane than '=', so a tag follows it
	logic soh_last;

	assign soh_here = (soh_i != `FIX_POS_NONE);
	assign sep_here = (sep_i != `FIX_POS_NONE);
	assign soh_last = (soh_i < sep_i);

	// field open at the end of the word
	always_comb begin
		case ({soh_here, sep_here})
			2'b11: begin
				tag_status_o = soh_last;
				value_status_o = !soh_last;
			end
			2'b10: begin
				tag_status_o = 1'b1;
				value_status_o = 1'b0;
			end
			2'b01: begin
				tag_status_o = 1'b0;
				value_status_o = 1'b1;
			end
			default: begin
				// no delimiter, the open field runs on
				tag_status_o = tag_status_i;
				value_status_o = value_status_i;
			end
		endcase
	end

	// per lane: delimiter, next field or continuation
	always_comb begin
		lane_pos_t lane;
		logic after_soh;
		logic after_sep;

		for (int k = LANES - 1; k >= 0; k--) begin
			lane = lane_pos_t'(k);
			after_soh = soh_here && (lane < soh_i);
			after_sep = sep_here && (lane < sep_i);
			out_o[8*k +: 8] = data_i[8*k +: 8];
			tag_valid_o[k] = 1'b0;
			value_valid_o[k] = 1'b0;
			if ((lane == soh_i) || (lane == sep_i)) begin
				out_o[8*k +: 8] = 8'h00;
			end else if (after_soh && after_sep) begin
				// past both, the later delimiter opened this field
				tag_valid_o[k] = soh_last;
				value_valid_o[k] = !soh_last;
			end else if (after_soh) begin
				tag_valid_o[k] = 1'b1;
			end else if (after_sep) begin
				value_valid_o[k] = 1'b1;
			end else begin
				// ahead of any delimiter, same field as before
				tag_valid_o[k] = tag_status_i;
				value_valid_o[k] = value_status_i;
			end
		end
	end

endmodule

// ==== hw/fix_field_assembler.sv ====
/*
 * fix_field_assembler
 * field state, decimal tag and raw value accumulation,
 * pair push on the closing SOH, tag and length error pulses
 */
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_field_assembler (
	input  logic                             clk,
	input  logic                             reset_i,
	input  logic                             word_valid_i,
	input  logic                             bad_word_i,
	input  logic [31:0]                      out_i,
	input  logic [3:0]                       tag_valid_i,
	input  logic [3:0]                       value_valid_i,
	input  fix_proto_pkg::lane_pos_t         soh_pos_i,
	input  logic                             tag_status_i,
	input  logic                             value_status_i,
	output logic                             tag_status_o,
	output logic                             value_status_o,
	output logic                             pair_push_o,
	output logic [13:0]                      pair_tag_o,
	output logic [`FIX_VALUE_BYTES*8-1:0]    pair_value_o,
	output logic [3:0]                       pair_len_o,
	output logic                             err_tag_o,
	output logic                             err_len_o
);
	import fix_proto_pkg::*;

	field_state_e state, state_n;
	logic [13:0] tag_acc, tag_n;
	logic [2:0] digits, digits_n;
	logic [`FIX_VALUE_BYTES*8-1:0] val_acc, val_n;
	logic [3:0] len, len_n;
	logic push_n;
	logic err_tag_n;
	logic err_len_n;
	logic [13:0] push_tag;
	logic [`FIX_VALUE_BYTES*8-1:0] push_val;
	logic [3:0] push_len;

	// walk the lanes in stream order, lane 3 first
	always_comb begin
		logic [7:0] lane_byte;
		logic is_digit;

		state_n = state;
		tag_n = tag_acc;
		digits_n = digits;
		val_n = val_acc;
		len_n = len;
		push_n = 1'b0;
		err_tag_n = 1'b0;
		err_len_n = 1'b0;
		push_tag = tag_acc;
		push_val = val_acc;
		push_len = len;
		for (int k = LANES - 1; k >= 0; k--) begin
			lane_byte = out_i[8*k +: 8];
			is_digit = (lane_byte >= 8'h30) && (lane_byte <= 8'h39);
			if (lane_pos_t'(k) == soh_pos_i) begin
				// only a field that reached its value makes a pair
				push_n = (state_n == IN_VALUE);
				push_tag = tag_n;
				push_val = val_n;
				push_len = len_n;
				state_n = IN_TAG;
				tag_n = '0;
				digits_n = '0;
				val_n = '0;
				len_n = '0;
			end else if (state_n != SKIP) begin
				if (tag_valid_i[k]) begin
					if (!is_digit || (digits_n == `FIX_TAG_DIGITS)) begin
						err_tag_n = 1'b1;
						state_n = SKIP;
					end else begin
						tag_n = tag_n * 14'd10 + 14'(lane_byte - 8'h30);
						digits_n = digits_n + 3'd1;
					end
				end else if (value_valid_i[k]) begin
					if (len_n == `FIX_VALUE_BYTES) begin
						err_len_n = 1'b1;
						state_n = SKIP;
					end else begin
						val_n = {val_n[`FIX_VALUE_BYTES*8-9:0], lane_byte};
						len_n = len_n + 4'd1;
					end
				end else if (state_n == IN_TAG) begin
					// unmarked lane outside SKIP is the '='
					state_n = IN_VALUE;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= IN_TAG;
			tag_status_o <= 1'b1;
			value_status_o <= 1'b0;
			tag_acc <= '0;
			digits <= '0;
			val_acc <= '0;
			len <= '0;
			pair_push_o <= 1'b0;
			err_tag_o <= 1'b0;
			err_len_o <= 1'b0;
		end else begin
			pair_push_o <= 1'b0;
			err_tag_o <= 1'b0;
			err_len_o <= 1'b0;
			if (word_valid_i && bad_word_i) begin
				// open field is lost with the word
				state <= SKIP;
			end else if (word_valid_i) begin
				state <= state_n;
				tag_status_o <= tag_status_i;
				value_status_o <= value_status_i;
				tag_acc <= tag_n;
				digits <= digits_n;
				val_acc <= val_n;
				len <= len_n;
				pair_push_o <= push_n;
				err_tag_o <= err_tag_n;
				err_len_o <= err_len_n;
			end
		end
	end

	// pair payload, valid with pair_push_o
	always_ff @(posedge clk) begin
		if (word_valid_i && !bad_word_i && push_n) begin
			pair_tag_o <= push_tag;
			pair_value_o <= push_val;
			pair_len_o <= push_len;
		end
	end

endmodule

// ==== hw/fix_wb_regs.sv ====
/*
 * fix_wb_regs
 * wishbone classic slave, register decode and ack,
 * DATA word hand-off, 4-entry pair queue, sticky errors
 */
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_wb_regs (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic                          cyc_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  fix_bus_pkg::reg_addr_e        adr_i,
	input  logic [31:0]                   dat_i,
	output logic [31:0]                   dat_o,
	output logic                          ack_o,
	output logic [31:0]                   word_o,
	output logic                          word_valid_o,
	input  logic                          bad_word_i,
	input  logic                          pair_push_i,
	input  logic [13:0]                   pair_tag_i,
	input  logic [`FIX_VALUE_BYTES*8-1:0] pair_value_i,
	input  logic [3:0]                    pair_len_i,
	input  logic                          err_tag_i,
	input  logic                          err_len_i
);
	import fix_bus_pkg::*;

	logic [13:0] q_tag [`FIX_QUEUE_DEPTH];
	logic [`FIX_VALUE_BYTES*8-1:0] q_value [`FIX_QUEUE_DEPTH];
	logic [3:0] q_len [`FIX_QUEUE_DEPTH];
	logic [$clog2(`FIX_QUEUE_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic [ERR_BITS-1:0] errors, err_set;
	logic req;
	logic room;
	logic accept;
	logic wr_word;
	logic pop;
	logic clr_err;
	logic [31:0] rd_data;

	// a new request, not the one being acked
	assign req = cyc_i && stb_i && !ack_o;
	// words and pushes still in the pipe also claim a slot
	assign room = (4'(count) + 4'(word_valid_o) + 4'(pair_push_i)) < 4'(`FIX_QUEUE_DEPTH);
	assign accept = req && (!we_i || (adr_i != REG_DATA) || room);
	assign wr_word = accept && we_i && (adr_i == REG_DATA);
	assign pop = accept && !we_i && (adr_i == REG_VAL_LO) && (count != '0);
	assign clr_err = accept && we_i && (adr_i == REG_STATUS);

	always_comb begin
		err_set = '0;
		err_set[ERR_BAD_WORD] = word_valid_o && bad_word_i;
		err_set[ERR_BAD_TAG] = err_tag_i;
		err_set[ERR_LONG_VAL] = err_len_i;
	end

	// read data from the queue head
	always_comb begin
		rd_data = '0;
		case (adr_i)
			REG_STATUS: begin
				rd_data[COUNT_BITS-1:0] = count;
				rd_data[ERR_LSB +: ERR_BITS] = errors;
			end
			REG_TAG:     rd_data[13:0] = q_tag[rd_ptr];
			REG_VAL_HI:  rd_data = q_value[rd_ptr][63:32];
			REG_VAL_LO:  rd_data = q_value[rd_ptr][31:0];
			REG_VAL_LEN: rd_data[3:0] = q_len[rd_ptr];
			default:     rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_o <= 1'b0;
			word_valid_o <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			errors <= '0;
		end else begin
			ack_o <= accept;
			word_valid_o <= wr_word;
			if (pair_push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + COUNT_BITS'(pair_push_i) - COUNT_BITS'(pop);
			// new errors win over a clear in the same cycle
			errors <= (clr_err ? '0 : errors) | err_set;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_word)
			word_o <= dat_i;
		if (accept)
			dat_o <= rd_data;
		if (pair_push_i) begin
			q_tag[wr_ptr] <= pair_tag_i;
			q_value[wr_ptr] <= pair_value_i;
			q_len[wr_ptr] <= pair_len_i;
		end
	end

endmodule

// ==== hw/fix_parser_top.sv ====
/*
 * fix_parser_top
 * register block, delimiter finder, field splitter
 * and field assembler of the fix parser
 */
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_parser_top (
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  logic                   we_i,
	input  fix_bus_pkg::reg_addr_e adr_i,
	input  logic [31:0]            dat_i,
	output logic [31:0]            dat_o,
	output logic                   ack_o
);
	import fix_proto_pkg::*;

	logic [31:0] word;
	logic word_valid;
	lane_pos_t soh_pos, sep_pos;
	logic bad_word;
	logic [31:0] field_data;
	logic [3:0] tag_valid, value_valid;
	// splitter result and the assembler's registered copy
	logic tag_status_n, value_status_n;
	logic tag_status_q, value_status_q;
	logic pair_push;
	logic [13:0] pair_tag;
	logic [`FIX_VALUE_BYTES*8-1:0] pair_value;
	logic [3:0] pair_len;
	logic err_tag, err_len;

	fix_wb_regs fix_wb_regs_i (
		.clk          (clk),
		.reset_i      (reset_i),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.we_i         (we_i),
		.adr_i        (adr_i),
		.dat_i        (dat_i),
		.dat_o        (dat_o),
		.ack_o        (ack_o),
		.word_o       (word),
		.word_valid_o (word_valid),
		.bad_word_i   (bad_word),
		.pair_push_i  (pair_push),
		.pair_tag_i   (pair_tag),
		.pair_value_i (pair_value),
		.pair_len_i   (pair_len),
		.err_tag_i    (err_tag),
		.err_len_i    (err_len)
	);

	fix_delim_finder fix_delim_finder_i (
		.word_i     (word),
		.soh_pos_o  (soh_pos),
		.sep_pos_o  (sep_pos),
		.bad_word_o (bad_word)
	);

	fix_field_splitter fix_field_splitter_i (
		.data_i         (word),
		.soh_i          (soh_pos),
		.sep_i          (sep_pos),
		.tag_status_i   (tag_status_q),
		.value_status_i (value_status_q),
		.out_o          (field_data),
		.tag_valid_o    (tag_valid),
		.value_valid_o  (value_valid),
		.tag_status_o   (tag_status_n),
		.value_status_o (value_status_n)
	);

	fix_field_assembler fix_field_assembler_i (
		.clk            (clk),
		.reset_i        (reset_i),
		.word_valid_i   (word_valid),
		.bad_word_i     (bad_word),
		.out_i          (field_data),
		.tag_valid_i    (tag_valid),
		.value_valid_i  (value_valid),
		.soh_pos_i      (soh_pos),
		.tag_status_i   (tag_status_n),
		.value_status_i (value_status_n),
		.tag_status_o   (tag_status_q),
		.value_status_o (value_status_q),
		.pair_push_o    (pair_push),
		.pair_tag_o     (pair_tag),
		.pair_value_o   (pair_value),
		.pair_len_o     (pair_len),
		.err_tag_o      (err_tag),
		.err_len_o      (err_len)
	);

endmodule

// ==== sim/fix_parser_asserts.sv ====
/*
 * bound checks on the fix parser register block
 * one-cycle ack, ack only with a request,
 * back-pressure while full, queue count bound
 */
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_parser_asserts (
	input logic                   clk,
	input logic                   reset_i,
	input logic                   cyc_i,
	input logic                   stb_i,
	input logic                   we_i,
	input fix_bus_pkg::reg_addr_e adr_i,
	input logic                   ack_i,
	input logic [2:0]             count_i
);
	import fix_bus_pkg::*;

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
		ack_i |=> !ack_i)
		else $error("ack held for more than one cycle");

	ack_with_request: assert property (@(posedge clk) disable iff (reset_i)
		ack_i |-> (cyc_i && stb_i))
		else $error("ack without an active strobe");

	// full queue withholds the DATA ack
	no_ack_when_full: assert property (@(posedge clk) disable iff (reset_i)
		(cyc_i && stb_i && we_i && adr_i == REG_DATA && count_i == `FIX_QUEUE_DEPTH)
		|=> !ack_i)
		else $error("DATA write acked while the queue was full");

	count_in_range: assert property (@(posedge clk) disable iff (reset_i)
		count_i <= `FIX_QUEUE_DEPTH)
		else $error("queue count above depth");

endmodule

// ==== sim/fix_parser_tb.sv ====
/*
 * testbench for fix_parser_top
 * wishbone bus tasks, FIX stream generator, reference parser,
 * pair comparison, cycle-count timeout
 */
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_parser_tb;
	import fix_bus_pkg::*;

	logic clk;
	logic reset_i;
	logic cyc, stb, we, ack;
	reg_addr_e adr;
	logic [31:0] wdata, rdata;
	logic [7:0] byte_q[$];
	logic [31:0] word_q[$];
	// reference parser state (0 tag, 1 value, 2 skip)
	int m_state, m_digits, m_len;
	logic [13:0] m_tag;
	logic [63:0] m_val;
	logic [2:0] m_err;
	logic [13:0] exp_tag[$];
	logic [63:0] exp_val[$];
	logic [3:0] exp_len[$];
	logic [31:0] got_tag, got_hi, got_lo, got_len;
	event pair_read;
	int cycles, words_written;

	fix_parser_top fix_parser_top_i (
		.clk(clk), .reset_i(reset_i), .cyc_i(cyc), .stb_i(stb), .we_i(we),
		.adr_i(adr), .dat_i(wdata), .dat_o(rdata), .ack_o(ack)
	);

	bind fix_wb_regs fix_parser_asserts fix_parser_asserts_i (
		.clk(clk), .reset_i(reset_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
		.adr_i(adr_i), .ack_i(ack_o), .count_i(count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 500 + 40 * words_written) begin
			$display("Simulation failed");
			$fatal(1, "run timed out after %0d cycles", cycles);
		end
	end

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// expected pairs and error flags of one bus word
	function automatic void model_parse(input logic [31:0] w);
		int n_soh = 0;
		int n_sep = 0;
		logic [7:0] b;
		for (int k = 3; k >= 0; k--) begin
			b = w[8*k +: 8];
			if (b == `FIX_SOH_CHAR)
				n_soh++;
			if (b == `FIX_SEP_CHAR)
				n_sep++;
		end
		if (n_soh > 1 || n_sep > 1) begin
			m_err[ERR_BAD_WORD] = 1'b1;
			m_state = 2;
			return;
		end
		for (int k = 3; k >= 0; k--) begin
			b = w[8*k +: 8];
			if (b == `FIX_SOH_CHAR) begin
				if (m_state == 1) begin
					exp_tag.push_back(m_tag);
					exp_val.push_back(m_val);
					exp_len.push_back(4'(m_len));
				end
				m_state = 0;
				m_tag = '0;
				m_digits = 0;
				m_val = '0;
				m_len = 0;
			end else if (m_state == 0) begin
				if (b == `FIX_SEP_CHAR) begin
					m_state = 1;
				end else if (b < 8'h30 || b > 8'h39 || m_digits == `FIX_TAG_DIGITS) begin
					m_err[ERR_BAD_TAG] = 1'b1;
					m_state = 2;
				end else begin
					m_tag = m_tag * 14'd10 + 14'(b - 8'h30);
					m_digits++;
				end
			end else if (m_state == 1 && b != `FIX_SEP_CHAR) begin
				if (m_len == `FIX_VALUE_BYTES) begin
					m_err[ERR_LONG_VAL] = 1'b1;
					m_state = 2;
				end else begin
					m_val = {m_val[55:0], b};
					m_len++;
				end
			end
		end
	endfunction

	task automatic add_text(input string s);
		for (int i = 0; i < s.len(); i++)
			byte_q.push_back(s.getc(i));
		byte_q.push_back(`FIX_SOH_CHAR);
	endtask

	// decimal tag and a random printable value without '='
	task automatic add_pair(input int tag, input int vlen);
		string s;
		logic [7:0] b;
		s = $sformatf("%0d=", tag);
		for (int i = 0; i < s.len(); i++)
			byte_q.push_back(s.getc(i));
		for (int i = 0; i < vlen; i++) begin
			b = 8'h21 + 8'($urandom_range(0, 93));
			if (b == `FIX_SEP_CHAR)
				b = 8'h41;
			byte_q.push_back(b);
		end
		byte_q.push_back(`FIX_SOH_CHAR);
	endtask

	// pad with one more pair to a whole word and pack the first byte high
	task automatic pack_words();
		int r;
		int vlen;
		logic [31:0] w;
		r = (4 - byte_q.size() % 4) % 4;
		if (r != 0) begin
			vlen = (r + 1) % 4;
			add_pair(1, (vlen == 0) ? 4 : vlen);
		end
		while (byte_q.size() > 0) begin
			w = '0;
			for (int k = 3; k >= 0; k--)
				w[8*k +: 8] = byte_q.pop_front();
			word_q.push_back(w);
		end
	endtask

	task automatic wb_write(input reg_addr_e a, input logic [31:0] d, input int limit,
		output logic acked);
		if (a == REG_DATA)
			words_written++;
		@(posedge clk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		wdata = d;
		acked = 1'b0;
		for (int i = 0; i < limit && !acked; i++) begin
			@(posedge clk);
			#1;
			acked = ack;
		end
		if (acked) begin
			@(posedge clk);
			#1;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wb_read(input reg_addr_e a, output logic [31:0] d);
		@(posedge clk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		do begin
			@(posedge clk);
			#1;
		end while (!ack);
		d = rdata;
		@(posedge clk);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	// VAL_LO last since its read pops the head
	task automatic pop_pair();
		wb_read(REG_TAG, got_tag);
		wb_read(REG_VAL_HI, got_hi);
		wb_read(REG_VAL_LEN, got_len);
		wb_read(REG_VAL_LO, got_lo);
		-> pair_read;
	endtask

	task automatic drain();
		logic [31:0] st;
		wb_read(REG_STATUS, st);
		repeat (st[2:0])
			pop_pair();
	endtask

	// a stalled write is withdrawn and retried after draining the queue
	task automatic write_word(input logic [31:0] w);
		logic acked;
		do begin
			wb_write(REG_DATA, w, 8, acked);
			if (!acked)
				drain();
		end while (!acked);
	endtask

	task automatic finish_stream(input logic [2:0] err_exp);
		logic [31:0] st;
		logic acked;
		repeat (3) @(posedge clk);
		drain();
		wb_read(REG_STATUS, st);
		check_eq(st[6:4], m_err, "status error flags");
		check_eq(m_err, err_exp, "model error flags");
		wb_write(REG_STATUS, 32'h0, 20, acked);
		check_eq(acked, 1'b1, "status clear ack");
		m_err = '0;
		wb_read(REG_STATUS, st);
		check_eq(st[6:4], 3'b000, "error flags after clear");
	endtask

	task automatic run_stream(input logic [2:0] err_exp);
		pack_words();
		while (word_q.size() > 0) begin
			model_parse(word_q[0]);
			write_word(word_q.pop_front());
		end
		finish_stream(err_exp);
	endtask

	always @(pair_read) begin
		check_eq(exp_tag.size() != 0, 1'b1, "pair present in model");
		check_eq(got_tag, 32'(exp_tag.pop_front()), "pair tag");
		check_eq({got_hi, got_lo}, exp_val.pop_front(), "pair value");
		check_eq(got_len, 32'(exp_len.pop_front()), "pair length");
	end

	initial begin
		logic acked;
		logic [31:0] st;
		logic [31:0] w0;
		void'($urandom(32'he50131c6));
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = REG_DATA;
		wdata = '0;
		reset_i = 1'b1;
		cycles = 0;
		words_written = 0;
		m_state = 0;
		m_digits = 0;
		m_len = 0;
		m_tag = '0;
		m_val = '0;
		m_err = '0;
		repeat (3) @(posedge clk);
		#1;
		reset_i = 1'b0;

		// 35=D in each lane alignment
		for (int s = 1; s <= 4; s++) begin
			add_pair(7, s);
			add_text("35=D");
			run_stream(3'b000);
		end

		// long tags and values spanning words
		for (int i = 0; i < 20; i++)
			add_pair($urandom_range(1000, 9999), $urandom_range(6, 8));
		run_stream(3'b000);

		// four pairs fill the queue so the ninth word stalls
		for (int i = 0; i < 4; i++)
			add_pair(10 + i, 4);
		add_pair(77, 4);
		pack_words();
		for (int i = 0; i < 8; i++) begin
			model_parse(word_q[0]);
			wb_write(REG_DATA, word_q.pop_front(), 8, acked);
			check_eq(acked, 1'b1, "write into free queue");
		end
		repeat (3) @(posedge clk);
		wb_read(REG_STATUS, st);
		check_eq(st[2:0], 3'd4, "queue count when full");
		w0 = word_q.pop_front();
		model_parse(w0);
		wb_write(REG_DATA, w0, 20, acked);
		check_eq(acked, 1'b0, "write stalled while full");
		pop_pair();
		wb_write(REG_DATA, w0, 8, acked);
		check_eq(acked, 1'b1, "stalled write after pop");
		model_parse(word_q[0]);
		write_word(word_q.pop_front());
		finish_stream(3'b000);

		// tag and length errors drop only their own pair
		add_pair(11, 3);
		add_text("3a=X");
		add_pair(12, 3);
		run_stream(3'b010);
		add_text("12345=X");
		add_pair(13, 2);
		run_stream(3'b010);
		add_text("5=123456789");
		add_pair(14, 5);
		run_stream(3'b100);

		// word with two SOH bytes and resync at the next SOH
		add_text("8=AB");
		add_text("99");
		add_text("7=Q");
		add_text("35=D");
		run_stream(3'b001);

		// random run
		for (int i = 0; i < 200; i++)
			add_pair($urandom_range(1, 9999), $urandom_range(1, 8));
		run_stream(3'b000);

		check_eq(exp_tag.size(), 0, "pairs left in model");
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hw
hw/fix_proto_pkg.sv
hw/fix_bus_pkg.sv
hw/fix_delim_finder.sv
hw/fix_field_splitter.sv
hw/fix_field_assembler.sv
hw/fix_wb_regs.sv
hw/fix_parser_top.sv
sim/fix_parser_asserts.sv
sim/fix_parser_tb.sv

// ==== Makefile ====
# Verilator build and run of the fix parser testbench

VERILATOR ?= verilator
TOP       ?= fix_parser_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
